/* Makefile */
TOP = w3d_host_tb

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"

test:
	verilator --binary --assert --top-module $(TOP) -f vlog.f -Mdir obj_dir
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "TEST PASSED"

clean:
	rm -rf obj_dir

/* src/w3d_host.sv */
`default_nettype none

module w3d_host import w3d_pkg::*;
#(
	parameter int MEM_WORDS   = 256,
	parameter int QUEUE_DEPTH = 4
)
(
	input  logic              clk,
	input  logic              reset,
	input  logic              run,

	input  logic              prog_we,
	input  logic [ADDR_W-1:0] prog_addr,
	input  logic [DATA_W-1:0] prog_data,

	output logic              out_valid,
	output logic [DATA_W-1:0] out_data,
	output logic              halted
);

	// instruction bus.
	logic              ibus_arvalid;
	logic              ibus_arready;
	logic [ADDR_W-1:0] ibus_araddr;
	logic              ibus_rvalid;
	logic              ibus_rready;
	logic [DATA_W-1:0] ibus_rdata;

	// data bus, read side.
	logic              dbus_arvalid;
	logic              dbus_arready;
	logic [ADDR_W-1:0] dbus_araddr;
	logic              dbus_rvalid;
	logic              dbus_rready;
	logic [DATA_W-1:0] dbus_rdata;

	// posted stores.
	logic              st_valid;
	logic              st_ready;
	logic [ADDR_W-1:0] st_addr;
	logic [DATA_W-1:0] st_data;
	logic              dbus_awvalid;
	logic              dbus_awready;
	logic [ADDR_W-1:0] dbus_awaddr;
	logic [DATA_W-1:0] dbus_wdata;
	logic              dbus_bvalid;

	w3d_host_core core
	(
		.clk,
		.reset,
		.run,
		.ibus_arvalid,
		.ibus_arready,
		.ibus_araddr,
		.ibus_rvalid,
		.ibus_rready,
		.ibus_rdata,
		.dbus_arvalid,
		.dbus_arready,
		.dbus_araddr,
		.dbus_rvalid,
		.dbus_rready,
		.dbus_rdata,
		.st_valid,
		.st_ready,
		.st_addr,
		.st_data,
		.dbus_bvalid,
		.out_valid,
		.out_data,
		.halted
	);

	w3d_store_queue #(.QUEUE_DEPTH(QUEUE_DEPTH)) queue
	(
		.clk,
		.reset,
		.st_valid,
		.st_ready,
		.st_addr,
		.st_data,
		.dbus_awvalid,
		.dbus_awready,
		.dbus_awaddr,
		.dbus_wdata
	);

	w3d_mem #(.MEM_WORDS(MEM_WORDS)) mem
	(
		.clk,
		.reset,
		.prog_we,
		.prog_addr,
		.prog_data,
		.ibus_arvalid,
		.ibus_arready,
		.ibus_araddr,
		.ibus_rvalid,
		.ibus_rready,
		.ibus_rdata,
		.dbus_arvalid,
		.dbus_arready,
		.dbus_araddr,
		.dbus_rvalid,
		.dbus_rready,
		.dbus_rdata,
		.dbus_awvalid,
		.dbus_awready,
		.dbus_awaddr,
		.dbus_wdata,
		.dbus_bvalid
	);

endmodule

`default_nettype wire

/* src/w3d_host_core.sv */
`default_nettype none

module w3d_host_core import w3d_pkg::*;
(
	input  logic              clk,
	input  logic              reset,
	input  logic              run,

	output logic              ibus_arvalid,
	input  logic              ibus_arready,
	output logic [ADDR_W-1:0] ibus_araddr,
	input  logic              ibus_rvalid,
	output logic              ibus_rready,
	input  logic [DATA_W-1:0] ibus_rdata,

	output logic              dbus_arvalid,
	input  logic              dbus_arready,
	output logic [ADDR_W-1:0] dbus_araddr,
	input  logic              dbus_rvalid,
	output logic              dbus_rready,
	input  logic [DATA_W-1:0] dbus_rdata,

	output logic              st_valid,
	input  logic              st_ready,
	output logic [ADDR_W-1:0] st_addr,
	output logic [DATA_W-1:0] st_data,
	input  logic              dbus_bvalid,

	output logic              out_valid,
	output logic [DATA_W-1:0] out_data,
	output logic              halted
);

	core_state_t       state;
	logic [ADDR_W-1:0] pc;
	logic [DATA_W-1:0] insn;
	logic [DATA_W-1:0] regs [4];
	logic [ADDR_W-1:0] pending; // posted stores without a response.

	opcode_t           op;
	logic [1:0]        rd;
	logic [1:0]        rs;
	logic [DATA_W-1:0] imm;
	logic [ADDR_W-1:0] addr;
	logic              st_fire;

	// ==============================
	// decode
	// ==============================
	assign op   = opcode_t'(insn[OPC_MSB:OPC_LSB]);
	assign rd   = insn[RD_MSB:RD_LSB];
	assign rs   = insn[RS_MSB:RS_LSB];
	assign imm  = DATA_W'(insn[IMM_MSB:IMM_LSB]); // zero extended.
	assign addr = insn[IMM_LSB +: ADDR_W];

	// ==============================
	// bus requests
	// ==============================
	assign ibus_arvalid = state == S_FETCH;
	assign ibus_araddr  = pc;
	assign ibus_rready  = state == S_WAIT_INSN;

	assign dbus_arvalid = state == S_EXEC && op == OP_LD;
	assign dbus_araddr  = addr;
	assign dbus_rready  = state == S_WAIT_LOAD;

	assign st_valid = state == S_EXEC && op == OP_ST;
	assign st_addr  = addr;
	assign st_data  = regs[rd];
	assign st_fire  = st_valid && st_ready;

	always_ff @(posedge clk) begin
		if (reset) begin
			pending <= '0;
		end else if (st_fire && !dbus_bvalid) begin
			pending <= pending + 1'b1;
		end else if (!st_fire && dbus_bvalid) begin
			pending <= pending - 1'b1;
		end
	end

	// ==============================
	// control
	// ==============================
	always_ff @(posedge clk) begin
		if (reset) begin
			state     <= S_HALTED;
			pc        <= '0;
			out_valid <= 1'b0;
			halted    <= 1'b0;
			for (int i = 0; i < 4; i++)
				regs[i] <= '0;
		end else begin
			out_valid <= 1'b0;
			case (state)
				S_HALTED:
					if (run && !halted)
						state <= S_FETCH;
				S_FETCH:
					if (ibus_arready)
						state <= S_WAIT_INSN;
				S_WAIT_INSN:
					if (ibus_rvalid) begin
						insn  <= ibus_rdata;
						pc    <= pc + 1'b1;
						state <= S_EXEC;
					end
				S_EXEC:
					case (op)
						OP_LI: begin
							regs[rd] <= imm;
							state    <= S_FETCH;
						end
						OP_LD:
							if (dbus_arready)
								state <= S_WAIT_LOAD;
						OP_ST:
							if (st_ready)
								state <= S_FETCH; // response is not awaited.
						OP_ADD: begin
							regs[rd] <= regs[rd] + regs[rs];
							state    <= S_FETCH;
						end
						OP_OUT: begin
							out_valid <= 1'b1;
							out_data  <= regs[rd];
							state     <= S_FETCH;
						end
						default:
							state <= S_DRAIN;
					endcase
				S_WAIT_LOAD:
					if (dbus_rvalid) begin
						regs[rd] <= dbus_rdata;
						state    <= S_FETCH;
					end
				S_DRAIN:
					if (pending == '0) begin
						halted <= 1'b1;
						state  <= S_HALTED;
					end
				default:
					state <= S_HALTED;
			endcase
		end
	end

endmodule

`default_nettype wire

/* src/w3d_mem.sv */
`default_nettype none

module w3d_mem import w3d_pkg::*;
#(
	parameter int MEM_WORDS = 256
)
(
	input  logic              clk,
	input  logic              reset,

	// program load, used while the core is idle.
	input  logic              prog_we,
	input  logic [ADDR_W-1:0] prog_addr,
	input  logic [DATA_W-1:0] prog_data,

	input  logic              ibus_arvalid,
	output logic              ibus_arready,
	input  logic [ADDR_W-1:0] ibus_araddr,
	output logic              ibus_rvalid,
	input  logic              ibus_rready,
	output logic [DATA_W-1:0] ibus_rdata,

	input  logic              dbus_arvalid,
	output logic              dbus_arready,
	input  logic [ADDR_W-1:0] dbus_araddr,
	output logic              dbus_rvalid,
	input  logic              dbus_rready,
	output logic [DATA_W-1:0] dbus_rdata,

	input  logic              dbus_awvalid,
	output logic              dbus_awready,
	input  logic [ADDR_W-1:0] dbus_awaddr,
	input  logic [DATA_W-1:0] dbus_wdata,
	output logic              dbus_bvalid
);

	logic [DATA_W-1:0] mem [MEM_WORDS];

	logic st_go;
	logic d_go;
	logic i_go;

	// ==============================
	// arbiter
	// ==============================
	// one port access per cycle. store, then load, then fetch.
	assign dbus_awready = !prog_we;

	// a queued store always wins, so loads see it first.
	assign dbus_arready = !prog_we && !dbus_awvalid && !dbus_rvalid;

	assign ibus_arready = !prog_we && !dbus_awvalid && !dbus_arvalid
		&& !ibus_rvalid;

	assign st_go = dbus_awvalid && dbus_awready;
	assign d_go  = dbus_arvalid && dbus_arready;
	assign i_go  = ibus_arvalid && ibus_arready;

	// ==============================
	// word array
	// ==============================
	always_ff @(posedge clk) begin
		if (prog_we)
			mem[prog_addr] <= prog_data;
		else if (st_go)
			mem[dbus_awaddr] <= dbus_wdata;

		if (d_go)
			dbus_rdata <= mem[dbus_araddr];
		if (i_go)
			ibus_rdata <= mem[ibus_araddr];
	end

	// ==============================
	// responses
	// ==============================
	always_ff @(posedge clk) begin
		if (reset) begin
			ibus_rvalid <= 1'b0;
			dbus_rvalid <= 1'b0;
			dbus_bvalid <= 1'b0;
		end else begin
			dbus_bvalid <= st_go; // single cycle, core never stalls it.

			if (d_go)
				dbus_rvalid <= 1'b1;
			else if (dbus_rready)
				dbus_rvalid <= 1'b0;

			if (i_go)
				ibus_rvalid <= 1'b1;
			else if (ibus_rready)
				ibus_rvalid <= 1'b0;
		end
	end

endmodule

`default_nettype wire

/* src/w3d_pkg.sv */
`default_nettype none

package w3d_pkg;

	localparam int DATA_W = 32; // data and instruction word.
	localparam int ADDR_W = 8; // word address.

	// ==============================
	// instruction word layout
	// ==============================
	localparam int OPC_MSB = 31;
	localparam int OPC_LSB = 28;
	localparam int RD_MSB  = 27;
	localparam int RD_LSB  = 26;
	localparam int RS_MSB  = 25;
	localparam int RS_LSB  = 24;
	localparam int IMM_MSB = 15;
	localparam int IMM_LSB = 0; // address is the low ADDR_W bits.

	// unlisted codes decode as halt.
	typedef enum logic [3:0] {
		OP_HALT = 4'h0,
		OP_LI   = 4'h1,
		OP_LD   = 4'h2,
		OP_ST   = 4'h3,
		OP_ADD  = 4'h4,
		OP_OUT  = 4'h5
	} opcode_t;

	typedef enum logic [2:0] {
		S_FETCH,
		S_WAIT_INSN,
		S_EXEC,
		S_WAIT_LOAD,
		S_DRAIN,
		S_HALTED
	} core_state_t;

endpackage

`default_nettype wire

/* src/w3d_store_queue.sv */
`default_nettype none

module w3d_store_queue import w3d_pkg::*;
#(
	parameter int QUEUE_DEPTH = 4
)
(
	input  logic              clk,
	input  logic              reset,

	input  logic              st_valid,
	output logic              st_ready,
	input  logic [ADDR_W-1:0] st_addr,
	input  logic [DATA_W-1:0] st_data,

	output logic              dbus_awvalid,
	input  logic              dbus_awready,
	output logic [ADDR_W-1:0] dbus_awaddr,
	output logic [DATA_W-1:0] dbus_wdata
);

	localparam int PTR_W = QUEUE_DEPTH > 1 ? $clog2(QUEUE_DEPTH) : 1;
	localparam int CNT_W = $clog2(QUEUE_DEPTH + 1);

	logic [ADDR_W-1:0] addr_q [QUEUE_DEPTH];
	logic [DATA_W-1:0] data_q [QUEUE_DEPTH];
	logic [PTR_W-1:0]  wr_ptr;
	logic [PTR_W-1:0]  rd_ptr;
	logic [CNT_W-1:0]  count;
	logic              push;
	logic              pop;

	assign st_ready     = count != CNT_W'(QUEUE_DEPTH);
	assign dbus_awvalid = count != '0;
	assign dbus_awaddr  = addr_q[rd_ptr];
	assign dbus_wdata   = data_q[rd_ptr];

	assign push = st_valid && st_ready;
	assign pop  = dbus_awvalid && dbus_awready;

	// entry storage.
	always_ff @(posedge clk) begin
		if (push) begin
			addr_q[wr_ptr] <= st_addr;
			data_q[wr_ptr] <= st_data;
		end
	end

	// ==============================
	// pointers and occupancy
	// ==============================
	always_ff @(posedge clk) begin
		if (reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (push)
				wr_ptr <= wr_ptr == PTR_W'(QUEUE_DEPTH - 1) ? '0 : wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= rd_ptr == PTR_W'(QUEUE_DEPTH - 1) ? '0 : rd_ptr + 1'b1;
			if (push && !pop)
				count <= count + 1'b1;
			else if (pop && !push)
				count <= count - 1'b1;
		end
	end

endmodule

`default_nettype wire

/* test/w3d_host_props.sv */
`default_nettype none

// one valid/ready pair, plus a second pair and the halt outputs on the core side.
module w3d_host_props
#(
	parameter bit CORE_SIDE = 1'b1
)
(
	input logic clk,
	input logic reset,
	input logic a_valid,
	input logic a_ready,
	input logic b_valid,
	input logic b_ready,
	input logic out_valid,
	input logic halted
);

	property valid_holds(v, r);
		@(posedge clk) disable iff (reset) v && !r |=> v;
	endproperty

	a_holds: assert property (valid_holds(a_valid, a_ready))
		else $error("valid on the first bus dropped before ready");

	if (CORE_SIDE) begin : core_checks
		b_holds: assert property (valid_holds(b_valid, b_ready))
			else $error("valid on the second bus dropped before ready");

		quiet_when_halted: assert property (@(posedge clk) disable iff (reset)
			halted |-> !out_valid)
			else $error("out_valid high while halted");

		halt_sticks: assert property (@(posedge clk) disable iff (reset) halted |=> halted)
			else $error("halted dropped without reset");
	end

endmodule

// ==============================
// attachment
// ==============================
bind w3d_host_core w3d_host_props #(.CORE_SIDE(1'b1)) core_props
(
	.clk(clk),
	.reset(reset),
	.a_valid(ibus_arvalid),
	.a_ready(ibus_arready),
	.b_valid(st_valid),
	.b_ready(st_ready),
	.out_valid(out_valid),
	.halted(halted)
);

// the store side is already watched on the core.
bind w3d_store_queue w3d_host_props #(.CORE_SIDE(1'b0)) queue_props
(
	.clk(clk),
	.reset(reset),
	.a_valid(dbus_awvalid),
	.a_ready(dbus_awready),
	.b_valid(1'b0),
	.b_ready(1'b0),
	.out_valid(1'b0),
	.halted(1'b0)
);

`default_nettype wire

/* test/w3d_host_tb.sv */
`default_nettype none

module w3d_host_tb import w3d_pkg::*;
();

	localparam int MEM_WORDS       = 256;
	localparam int QUEUE_DEPTH     = 4;
	localparam int DATA_WORDS      = 256;
	localparam int CYCLES_PER_WORD = 40;
	localparam int MARGIN_CYCLES   = 1000;
	localparam int QUIET_CYCLES    = 20; // watched after halt.

	logic              clk;
	logic              reset;
	logic              run;
	logic              prog_we;
	logic [ADDR_W-1:0] prog_addr;
	logic [DATA_W-1:0] prog_data;
	logic              out_valid;
	logic [DATA_W-1:0] out_data;
	logic              halted;

	logic [DATA_W-1:0] tdata [DATA_WORDS];
	logic [DATA_W-1:0] got [$];
	int                value_errors;
	int                other_errors;
	int                records;
	int                limit_cycles;

	w3d_host #(.MEM_WORDS(MEM_WORDS), .QUEUE_DEPTH(QUEUE_DEPTH)) dut0
	(
		.clk,
		.reset,
		.run,
		.prog_we,
		.prog_addr,
		.prog_data,
		.out_valid,
		.out_data,
		.halted
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// ==============================
	// data file walk
	// ==============================
	function automatic bit length_ok(input int ptr);
		return ptr < DATA_WORDS && !$isunknown(tdata[ptr]) && tdata[ptr] !== '0;
	endfunction

	function automatic int program_words();
		int ptr;
		int total;
		ptr   = 0;
		total = 0;
		while (length_ok(ptr)) begin
			total = total + int'(tdata[ptr]);
			ptr   = ptr + 1 + int'(tdata[ptr]); // now at the out count.
			ptr   = ptr + 1 + int'(tdata[ptr]);
		end
		return total;
	endfunction

	// ==============================
	// stimulus and collection
	// ==============================
	task automatic load_program(input int base, input int len);
		for (int i = 0; i < len; i++) begin
			@(posedge clk);
			prog_we   <= 1'b1;
			prog_addr <= ADDR_W'(i);
			prog_data <= tdata[base + i];
		end
		@(posedge clk);
		prog_we <= 1'b0;
	endtask

	task automatic apply_reset(input int rec);
		@(posedge clk);
		reset <= 1'b1;
		repeat (8) @(posedge clk);
		reset <= 1'b0;
		@(negedge clk);
		if (halted !== 1'b0 || out_valid !== 1'b0) begin
			$display("CHECK FAILED at %0t: record %0d halted or out_valid not low after reset",
				$time, rec);
			value_errors++;
		end
	endtask

	task automatic collect_outputs(input int rec);
		got.delete();
		while (halted !== 1'b1) begin
			@(negedge clk);
			if (out_valid === 1'b1)
				got.push_back(out_data);
		end
		repeat (QUIET_CYCLES) begin
			@(negedge clk);
			if (out_valid !== 1'b0) begin
				$display("CHECK FAILED at %0t: record %0d out_valid pulsed after halt",
					$time, rec);
				value_errors++;
			end
			if (halted !== 1'b1) begin
				$display("CHECK FAILED at %0t: record %0d halted dropped", $time, rec);
				value_errors++;
			end
		end
	endtask

	task automatic compare_outputs(input int rec, input int base, input int count);
		if (got.size() != count) begin
			$display("CHECK FAILED at %0t: record %0d gave %0d outputs, expected %0d",
				$time, rec, got.size(), count);
			value_errors++;
		end
		for (int i = 0; i < count && i < got.size(); i++) begin
			if (got[i] !== tdata[base + i]) begin
				$display("CHECK FAILED at %0t: record %0d output %0d is %h, expected %h",
					$time, rec, i, got[i], tdata[base + i]);
				value_errors++;
			end
		end
	endtask

	// ==============================
	// main sequence
	// ==============================
	initial begin
		int ptr;
		int len;
		int count;
		reset     <= 1'b1;
		run       <= 1'b0;
		prog_we   <= 1'b0;
		prog_addr <= '0;
		prog_data <= '0;
		value_errors = 0;
		other_errors = 0;
		records      = 0;
		$readmemh("test/w3d_host_testdata.hex", tdata);
		limit_cycles = CYCLES_PER_WORD * program_words() + MARGIN_CYCLES;

		repeat (8) @(posedge clk);
		reset <= 1'b0;

		ptr = 0;
		while (length_ok(ptr)) begin
			len = int'(tdata[ptr]);
			@(posedge clk);
			run <= 1'b0;
			load_program(ptr + 1, len);
			apply_reset(records);
			@(posedge clk);
			run <= 1'b1;
			ptr   = ptr + 1 + len;
			count = int'(tdata[ptr]);
			collect_outputs(records);
			compare_outputs(records, ptr + 1, count);
			ptr     = ptr + 1 + count;
			records = records + 1;
		end

		if (records == 0) begin
			$display("no records found in the data file");
			other_errors++;
		end

		$display("errors: %0d value mismatches, %0d other failures, %0d records run",
			value_errors, other_errors, records);
		if (value_errors == 0 && other_errors == 0)
			$display("TEST PASSED");
		else
			$display("TEST FAILED");
		$finish;
	end

	// limit grows with the total program size.
	initial begin
		wait (limit_cycles > 0);
		repeat (limit_cycles) @(posedge clk);
		$display("timed out after %0d cycles waiting for the core to halt", limit_cycles);
		$display("TEST FAILED");
		$finish;
	end

endmodule

`default_nettype wire

/* test/w3d_host_testdata.hex */
// record: program length, program words from address 0,
//         expected OUT count, expected OUT values. a zero length ends the file.

// li then out on every register.
00000009
10001234 1400BEEF 18000001 1C00FFFF
50000000 54000000 58000000 5C000000
00000000
00000004
00001234 0000BEEF 00000001 0000FFFF

// add chain, then a sum that wraps. words 10 and 11 are data.
0000000C
18000007 1C000009 4B000000 4A000000 58000000
2000000A 2400000B 41000000 50000000 00000000
FFFFFFF0 00000025
00000002
00000020 00000015

// store, then an immediate load of the same word.
00000005
1400A5A5 34000080 28000080 58000000 00000000
00000001
0000A5A5

// six stores back to back, then six loads.
00000017
10000011 14000022 18000033 1C000044
30000090 34000091 38000092 3C000093 30000094 34000095
2C000090 5C000000 2C000091 5C000000 2C000092 5C000000
2C000093 5C000000 2C000094 5C000000 2C000095 5C000000
00000000
00000006
00000011 00000022 00000033 00000044 00000011 00000022

// halt at once, nothing emitted.
00000001
00000000
00000000

// undefined opcode with a store still draining.
00000006
10000077 300000A0 50000000 F0000000 50000000 00000000
00000001
00000077

00000000

/* vlog.f */
src/w3d_pkg.sv
src/w3d_store_queue.sv
src/w3d_mem.sv
src/w3d_host_core.sv
src/w3d_host.sv
test/w3d_host_props.sv
test/w3d_host_tb.sv
